//--- design/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int tag_w     = 20;
    localparam int index_w   = 8;
    localparam int offset_w  = 4;
    localparam int num_sets  = 256;
    localparam int num_banks = 4;
    localparam int word_w    = 32;
    localparam int line_w    = 128;

    // replacement lfsr reset value
    localparam logic [7:0] lfsr_seed = 8'h01;

    // main state machine codes
    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_lookup  = 3'd1;
    localparam logic [2:0] st_miss    = 3'd2;
    localparam logic [2:0] st_replace = 3'd3;
    localparam logic [2:0] st_refill  = 3'd4;

    // store buffer states
    localparam logic sb_idle  = 1'b0;
    localparam logic sb_write = 1'b1;

    // one address word, either flat or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [1:0]         bank;
            logic [1:0]         byte_sel;
        } fields;
    } dcache_addr_u;

endpackage

//--- design/dcache_data_bank.sv
module dcache_data_bank (
    input  logic                               clk,
    input  logic [3:0]                         wen,
    input  logic [dcache_pkg::index_w-1:0]     addr,
    input  logic [dcache_pkg::word_w-1:0]      wdata,
    output logic [dcache_pkg::word_w-1:0]      rdata
);

    logic [dcache_pkg::word_w-1:0] mem [dcache_pkg::num_sets];

    // byte-wise write, read returns the old word on a collision
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) begin
                mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        rdata <= mem[addr];
    end

endmodule

//--- design/dcache_tag_array.sv
module dcache_tag_array (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [dcache_pkg::index_w-1:0]     addr,
    input  logic                               tv_wen,
    input  logic [dcache_pkg::tag_w-1:0]       wtag,
    output logic [dcache_pkg::tag_w-1:0]       rtag,
    output logic                               rvalid,
    input  logic [dcache_pkg::index_w-1:0]     d_addr,
    input  logic                               d_wen,
    input  logic                               d_wdata,
    output logic                               rdirty
);

    logic [dcache_pkg::tag_w-1:0]    tag_mem [dcache_pkg::num_sets];
    logic [dcache_pkg::num_sets-1:0] valid_bits;
    logic [dcache_pkg::num_sets-1:0] dirty_bits;

    always_ff @(posedge clk) begin
        if (tv_wen) begin
            tag_mem[addr] <= wtag;
        end
        rtag <= tag_mem[addr];
    end

    // a refill is the only way a line becomes valid
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            rvalid     <= 1'b0;
        end else begin
            if (tv_wen) begin
                valid_bits[addr] <= 1'b1;
            end
            rvalid <= valid_bits[addr];
        end
    end

    // dirty bits have their own address port
    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty_bits <= '0;
        end else if (d_wen) begin
            dirty_bits[d_addr] <= d_wdata;
        end
    end

    assign rdirty = dirty_bits[d_addr];

endmodule

//--- design/dcache_store_buffer.sv
module dcache_store_buffer (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               load,
    input  logic                               hit_way,
    input  logic [dcache_pkg::index_w-1:0]     req_index,
    input  logic [1:0]                         req_bank,
    input  logic [3:0]                         req_wstrb,
    input  logic [dcache_pkg::word_w-1:0]      req_wdata,
    output logic                               pending,
    output logic                               buf_way,
    output logic [dcache_pkg::index_w-1:0]     buf_index,
    output logic [1:0]                         buf_bank,
    output logic [3:0]                         buf_wstrb,
    output logic [dcache_pkg::word_w-1:0]      buf_wdata
);

    logic state_q;
    logic state_d;

    // a store hit in lookup always moves to write, back to back included
    assign state_d = load ? dcache_pkg::sb_write : dcache_pkg::sb_idle;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= dcache_pkg::sb_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            buf_way   <= hit_way;
            buf_index <= req_index;
            buf_bank  <= req_bank;
            buf_wstrb <= req_wstrb;
            buf_wdata <= req_wdata;
        end
    end

    assign pending = state_q == dcache_pkg::sb_write;

endmodule

//--- design/dcache_main_fsm.sv
module dcache_main_fsm (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               valid,
    input  logic                               op,
    input  logic [dcache_pkg::index_w-1:0]     index,
    input  logic [dcache_pkg::tag_w-1:0]       tag,
    input  logic [dcache_pkg::offset_w-1:0]    offset,
    input  logic [3:0]                         wstrb,
    input  logic [dcache_pkg::word_w-1:0]      wdata,
    input  logic                               hit,
    input  logic                               conflict,
    input  logic                               victim_valid,
    input  logic                               victim_dirty,
    input  logic [dcache_pkg::tag_w-1:0]       victim_tag,
    input  logic                               rd_rdy,
    input  logic                               ret_valid,
    input  logic                               ret_last,
    input  logic                               wr_rdy,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic                               state_idle,
    output logic                               state_lookup,
    output logic                               state_refill,
    output logic                               store_hit,
    output logic                               req_op,
    output logic [dcache_pkg::index_w-1:0]     req_index,
    output logic [dcache_pkg::tag_w-1:0]       req_tag,
    output logic [dcache_pkg::offset_w-1:0]    req_offset,
    output logic [3:0]                         req_wstrb,
    output logic [dcache_pkg::word_w-1:0]      req_wdata,
    output logic [1:0]                         refill_cnt,
    output logic                               victim_way,
    output logic [dcache_pkg::tag_w-1:0]       wb_tag,
    output logic                               rd_req,
    output logic                               wr_req
);

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       state_miss;
    logic       accept;
    logic       refill_done;
    logic       wb_needed;
    logic       wb_valid;
    logic       miss_first;
    logic [7:0] lfsr;

    assign state_idle   = state_q == dcache_pkg::st_idle;
    assign state_lookup = state_q == dcache_pkg::st_lookup;
    assign state_miss   = state_q == dcache_pkg::st_miss;
    assign state_refill = state_q == dcache_pkg::st_refill;

    assign addr_ok     = (state_idle | (state_lookup & hit)) & ~conflict;
    assign accept      = valid & addr_ok;
    assign store_hit   = state_lookup & hit & req_op;
    assign refill_done = state_refill & ret_valid & ret_last;

    // stores answer in lookup, load misses on their own refill word
    assign data_ok = (state_lookup & (hit | req_op))
                   | (state_refill & ret_valid & ~req_op & (refill_cnt == req_offset[3:2]));

    // first miss cycle lets the banks settle on the victim set
    assign wb_needed = wb_valid & victim_dirty;
    assign wr_req    = state_miss & ~miss_first & wb_needed;
    assign rd_req    = state_q == dcache_pkg::st_replace;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::st_idle: begin
                if (accept) begin
                    state_d = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_lookup: begin
                if (!hit) begin
                    state_d = dcache_pkg::st_miss;
                end else if (accept) begin
                    state_d = dcache_pkg::st_lookup;
                end else begin
                    state_d = dcache_pkg::st_idle;
                end
            end
            dcache_pkg::st_miss: begin
                if (!wb_needed || (wr_req && wr_rdy)) begin
                    state_d = dcache_pkg::st_replace;
                end
            end
            dcache_pkg::st_replace: begin
                if (rd_rdy) begin
                    state_d = dcache_pkg::st_refill;
                end
            end
            dcache_pkg::st_refill: begin
                if (refill_done) begin
                    state_d = dcache_pkg::st_idle;
                end
            end
            default: begin
                state_d = dcache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q    <= dcache_pkg::st_idle;
            miss_first <= 1'b0;
            refill_cnt <= 2'd0;
            lfsr       <= dcache_pkg::lfsr_seed;
        end else begin
            state_q    <= state_d;
            miss_first <= state_lookup;
            if (refill_done) begin
                refill_cnt <= 2'd0;
                lfsr       <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end else if (state_refill && ret_valid) begin
                refill_cnt <= refill_cnt + 2'd1;
            end
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    // lookup still shows the request's set, so keep the victim from there
    always_ff @(posedge clk) begin
        if (state_lookup) begin
            wb_tag   <= victim_tag;
            wb_valid <= victim_valid;
        end
    end

    assign victim_way = lfsr[0];

endmodule

//--- design/dcache_top.sv
module dcache_top (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               valid,
    input  logic                               op,
    input  logic [dcache_pkg::index_w-1:0]     index,
    input  logic [dcache_pkg::tag_w-1:0]       tag,
    input  logic [dcache_pkg::offset_w-1:0]    offset,
    input  logic [3:0]                         wstrb,
    input  logic [dcache_pkg::word_w-1:0]      wdata,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic [dcache_pkg::word_w-1:0]      rdata,
    output logic                               rd_req,
    output logic [31:0]                        rd_addr,
    input  logic                               rd_rdy,
    input  logic                               ret_valid,
    input  logic                               ret_last,
    input  logic [dcache_pkg::word_w-1:0]      ret_data,
    output logic                               wr_req,
    output logic [31:0]                        wr_addr,
    output logic [dcache_pkg::line_w-1:0]      wr_data,
    input  logic                               wr_rdy
);

    logic                            state_idle;
    logic                            state_lookup;
    logic                            state_refill;
    logic                            store_hit;
    logic                            req_op;
    logic [dcache_pkg::index_w-1:0]  req_index;
    logic [dcache_pkg::tag_w-1:0]    req_tag;
    logic [dcache_pkg::offset_w-1:0] req_offset;
    logic [3:0]                      req_wstrb;
    logic [dcache_pkg::word_w-1:0]   req_wdata;
    logic [1:0]                      refill_cnt;
    logic                            victim_way;
    logic [dcache_pkg::tag_w-1:0]    wb_tag;
    logic                            hit;
    logic                            conflict;
    logic                            sb_pending;
    logic                            sb_way;
    logic [dcache_pkg::index_w-1:0]  sb_index;
    logic [1:0]                      sb_bank;
    logic [3:0]                      sb_wstrb;
    logic [dcache_pkg::word_w-1:0]   sb_wdata;
    logic [dcache_pkg::tag_w-1:0]    rtag [2];
    logic                            rvalid [2];
    logic                            rdirty [2];
    logic                            way_hit [2];
    logic [dcache_pkg::word_w-1:0]   bank_rdata [2][dcache_pkg::num_banks];
    logic [dcache_pkg::index_w-1:0]  set_index;
    logic [dcache_pkg::index_w-1:0]  dirty_index;
    logic                            dirty_wdata;
    logic                            refill_wr;
    logic [dcache_pkg::word_w-1:0]   store_mask;
    logic [dcache_pkg::word_w-1:0]   refill_word;
    logic [dcache_pkg::word_w-1:0]   bank_wdata;
    dcache_pkg::dcache_addr_u        rd_line;
    dcache_pkg::dcache_addr_u        wr_line;

    dcache_main_fsm u_main_fsm (
        .clk(clk), .resetn(resetn), .valid(valid), .op(op), .index(index), .tag(tag),
        .offset(offset), .wstrb(wstrb), .wdata(wdata), .hit(hit), .conflict(conflict),
        .victim_valid(rvalid[victim_way]), .victim_dirty(rdirty[victim_way]),
        .victim_tag(rtag[victim_way]), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .wr_rdy(wr_rdy), .addr_ok(addr_ok), .data_ok(data_ok),
        .state_idle(state_idle), .state_lookup(state_lookup), .state_refill(state_refill),
        .store_hit(store_hit), .req_op(req_op), .req_index(req_index), .req_tag(req_tag),
        .req_offset(req_offset), .req_wstrb(req_wstrb), .req_wdata(req_wdata),
        .refill_cnt(refill_cnt), .victim_way(victim_way), .wb_tag(wb_tag),
        .rd_req(rd_req), .wr_req(wr_req)
    );

    dcache_store_buffer u_store_buffer (
        .clk(clk), .resetn(resetn), .load(store_hit), .hit_way(way_hit[1]),
        .req_index(req_index), .req_bank(req_offset[3:2]), .req_wstrb(req_wstrb),
        .req_wdata(req_wdata), .pending(sb_pending), .buf_way(sb_way),
        .buf_index(sb_index), .buf_bank(sb_bank), .buf_wstrb(sb_wstrb),
        .buf_wdata(sb_wdata)
    );

    // lookup reads the incoming set, a miss works on the buffered one
    assign set_index   = (state_idle | state_lookup) ? index : req_index;
    assign dirty_index = sb_pending ? sb_index : req_index;
    // store miss leaves the refilled line dirty
    assign dirty_wdata = sb_pending | req_op;
    assign refill_wr   = state_refill & ret_valid;

    dcache_tag_array u_tag_way0 (
        .clk(clk), .resetn(resetn), .addr(set_index),
        .tv_wen(refill_wr & ret_last & ~victim_way), .wtag(req_tag),
        .rtag(rtag[0]), .rvalid(rvalid[0]), .d_addr(dirty_index),
        .d_wen((sb_pending & ~sb_way) | (refill_wr & ret_last & ~victim_way)),
        .d_wdata(dirty_wdata), .rdirty(rdirty[0])
    );

    dcache_tag_array u_tag_way1 (
        .clk(clk), .resetn(resetn), .addr(set_index),
        .tv_wen(refill_wr & ret_last & victim_way), .wtag(req_tag),
        .rtag(rtag[1]), .rvalid(rvalid[1]), .d_addr(dirty_index),
        .d_wen((sb_pending & sb_way) | (refill_wr & ret_last & victim_way)),
        .d_wdata(dirty_wdata), .rdirty(rdirty[1])
    );

    assign way_hit[0] = rvalid[0] & (rtag[0] == req_tag);
    assign way_hit[1] = rvalid[1] & (rtag[1] == req_tag);
    assign hit        = way_hit[0] | way_hit[1];

    // a load may not read a word the store path has not written yet
    assign conflict = ~op & ((state_lookup & req_op
                              & ({tag, index, offset[3:2]}
                                 == {req_tag, req_index, req_offset[3:2]}))
                             | (sb_pending & (offset[3:2] == sb_bank)));

    // merge the missed store into its refill word
    assign store_mask  = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}},
                          {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};
    assign refill_word = (req_op && refill_cnt == req_offset[3:2])
                       ? ((req_wdata & store_mask) | (ret_data & ~store_mask)) : ret_data;
    assign bank_wdata  = sb_pending ? sb_wdata : refill_word;

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < dcache_pkg::num_banks; b++) begin : g_bank
            dcache_data_bank u_bank (
                .clk(clk),
                .wen((sb_pending && sb_way == w && sb_bank == b) ? sb_wstrb
                     : (refill_wr && victim_way == w && refill_cnt == b) ? 4'hf : 4'h0),
                .addr((sb_pending && sb_bank == b) ? sb_index : set_index),
                .wdata(bank_wdata),
                .rdata(bank_rdata[w][b])
            );
        end
    end

    assign rdata = state_lookup ? (way_hit[1] ? bank_rdata[1][req_offset[3:2]]
                                              : bank_rdata[0][req_offset[3:2]])
                                : ret_data;

    assign wr_data = {bank_rdata[victim_way][3], bank_rdata[victim_way][2],
                      bank_rdata[victim_way][1], bank_rdata[victim_way][0]};

    // line-aligned memory addresses
    always_comb begin
        rd_line.fields.tag      = req_tag;
        rd_line.fields.index    = req_index;
        rd_line.fields.bank     = 2'd0;
        rd_line.fields.byte_sel = 2'd0;
        wr_line.fields.tag      = wb_tag;
        wr_line.fields.index    = req_index;
        wr_line.fields.bank     = 2'd0;
        wr_line.fields.byte_sel = 2'd0;
    end

    assign rd_addr = rd_line.raw;
    assign wr_addr = wr_line.raw;

endmodule

//--- bench/dcache_mem_model.sv
module dcache_mem_model (
    input  logic                               clk,
    input  logic                               stall_en,
    input  logic                               rd_req,
    input  logic [31:0]                        rd_addr,
    output logic                               rd_rdy,
    output logic                               ret_valid,
    output logic                               ret_last,
    output logic [dcache_pkg::word_w-1:0]      ret_data,
    input  logic                               wr_req,
    input  logic [31:0]                        wr_addr,
    input  logic [dcache_pkg::line_w-1:0]      wr_data,
    output logic                               wr_rdy
);

    // 32 KB of words, filled by the testbench before reset ends
    logic [dcache_pkg::word_w-1:0] mem [8192];
    integer                        seed;
    logic [31:0]                   rnd;
    logic                          rd_go;
    logic                          wr_go;
    logic                          busy;
    logic [1:0]                    ret_cnt;
    logic [10:0]                   line_idx;

    initial begin
        seed      = 32'h9511;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        busy      = 1'b0;
        ret_cnt   = 2'd0;
        line_idx  = '0;
    end

    always @(negedge clk) begin
        // one draw per edge, stalled or not
        rnd   = $random(seed);
        rd_go = rd_req && !busy && (!stall_en || rnd[1:0] != 2'd0);
        wr_go = wr_req && (!stall_en || rnd[3:2] != 2'd0);

        // four words in bank order on consecutive cycles
        if (busy) begin
            ret_valid <= 1'b1;
            ret_last  <= ret_cnt == 2'd3;
            ret_data  <= mem[{line_idx, ret_cnt}];
            ret_cnt   <= ret_cnt + 2'd1;
            busy      <= ret_cnt != 2'd3;
        end else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
        end

        rd_rdy <= rd_go;
        if (rd_go) begin
            busy     <= 1'b1;
            ret_cnt  <= 2'd0;
            line_idx <= rd_addr[14:4];
        end

        // write-back lands before the handshake edge, data is stable here
        wr_rdy <= wr_go;
        if (wr_go) begin
            for (int b = 0; b < 4; b++) begin
                mem[{wr_addr[14:4], 2'(b)}] = wr_data[32*b +: 32];
            end
        end
    end

endmodule

//--- bench/dcache_assert.sv
module dcache_assert (
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  logic        addr_ok,
    input  logic        data_ok,
    input  logic        rd_req,
    input  logic        rd_rdy,
    input  logic [31:0] rd_addr,
    input  logic        wr_req,
    input  logic        wr_rdy,
    input  logic [31:0] wr_addr
);

    // failures so far, added to the error count at the end of the run
    int fail_cnt = 0;
    // accepted requests still waiting for data_ok
    int outstanding;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + ((valid && addr_ok) ? 1 : 0) - (data_ok ? 1 : 0);
        end
    end

    // read request held with its address until rd_rdy
    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else begin
        $error("rd_req or rd_addr changed before rd_rdy");
        fail_cnt++;
    end

    // same for the write-back request
    wr_req_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
    else begin
        $error("wr_req or wr_addr changed before wr_rdy");
        fail_cnt++;
    end

    // no answer while the cache has nothing in flight
    no_data_ok_idle: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> outstanding > 0)
    else begin
        $error("data_ok high with no accepted request outstanding");
        fail_cnt++;
    end

endmodule

bind dcache_top dcache_assert u_dcache_assert (
    .clk(clk), .resetn(resetn), .valid(valid), .addr_ok(addr_ok), .data_ok(data_ok),
    .rd_req(rd_req), .rd_rdy(rd_rdy), .rd_addr(rd_addr),
    .wr_req(wr_req), .wr_rdy(wr_rdy), .wr_addr(wr_addr)
);

//--- bench/dcache_tb.sv
module dcache_tb;

    logic                               clk;
    logic                               resetn;
    logic                               valid;
    logic                               op;
    logic [dcache_pkg::index_w-1:0]     index;
    logic [dcache_pkg::tag_w-1:0]       tag;
    logic [dcache_pkg::offset_w-1:0]    offset;
    logic [3:0]                         wstrb;
    logic [dcache_pkg::word_w-1:0]      wdata;
    logic                               addr_ok;
    logic                               data_ok;
    logic [dcache_pkg::word_w-1:0]      rdata;
    logic                               rd_req;
    logic [31:0]                        rd_addr;
    logic                               rd_rdy;
    logic                               ret_valid;
    logic                               ret_last;
    logic [dcache_pkg::word_w-1:0]      ret_data;
    logic                               wr_req;
    logic [31:0]                        wr_addr;
    logic [dcache_pkg::line_w-1:0]      wr_data;
    logic                               wr_rdy;
    logic                               stall_en;

    // expected memory image, word for word with the model
    logic [dcache_pkg::word_w-1:0]      shadow [8192];
    bit                                 evicted [2048];
    int                                 errors = 0;
    int                                 cycle_cnt = 0;

    dcache_top u_dcache_top (
        .clk(clk), .resetn(resetn), .valid(valid), .op(op), .index(index), .tag(tag),
        .offset(offset), .wstrb(wstrb), .wdata(wdata), .addr_ok(addr_ok),
        .data_ok(data_ok), .rdata(rdata), .rd_req(rd_req), .rd_addr(rd_addr),
        .rd_rdy(rd_rdy), .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    dcache_mem_model u_mem (
        .clk(clk), .stall_en(stall_en), .rd_req(rd_req), .rd_addr(rd_addr),
        .rd_rdy(rd_rdy), .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // a full run needs well under 1000 cycles even with stalls
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (wr_req && wr_rdy) begin
            evicted[wr_addr[14:4]] <= 1'b1;
        end
        if (cycle_cnt == 3000) begin
            $display("timeout after 3000 cycles, %0d errors so far", errors);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] fill_word(input int w);
        return (32'(w) * 32'h9e37_79b1) ^ 32'h3c6e_f372;
    endfunction

    function automatic logic [31:0] addr_of(input logic [dcache_pkg::tag_w-1:0] t,
                                            input logic [dcache_pkg::index_w-1:0] idx,
                                            input logic [1:0] bank);
        dcache_pkg::dcache_addr_u a;
        a.fields.tag      = t;
        a.fields.index    = idx;
        a.fields.bank     = bank;
        a.fields.byte_sel = 2'd0;
        return a.raw;
    endfunction

    // one request, lat counts cycles from acceptance to data_ok
    task automatic access(input logic st, input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] data, output logic [31:0] rd, output int lat);
        dcache_pkg::dcache_addr_u a;
        a.raw = addr;
        @(negedge clk);
        valid  = 1'b1;
        op     = st;
        tag    = a.fields.tag;
        index  = a.fields.index;
        offset = {a.fields.bank, a.fields.byte_sel};
        wstrb  = strb;
        wdata  = data;
        #1;
        while (!addr_ok) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        valid = 1'b0;
        lat   = 1;
        #1;
        while (!data_ok) begin
            @(negedge clk);
            #1;
            lat++;
        end
        rd = rdata;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] data);
        logic [31:0] rd;
        int          lat;
        access(1'b1, addr, strb, data, rd, lat);
        if (lat != 1) begin
            $display("Fail data_ok latency of store at %h: got %h expected %h", addr, lat, 1);
            errors++;
        end
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                shadow[addr[14:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // kind 1 expects a hit, 2 a miss, 0 either
    task automatic load_word(input logic [31:0] addr, input int kind);
        logic [31:0] rd;
        int          lat;
        access(1'b0, addr, 4'h0, 32'h0, rd, lat);
        if (rd !== shadow[addr[14:2]]) begin
            $display("Fail rdata at %h: got %h expected %h", addr, rd, shadow[addr[14:2]]);
            errors++;
        end
        if (kind == 1 && lat != 1) begin
            $display("Fail data_ok latency of load at %h: got %h expected %h", addr, lat, 1);
            errors++;
        end
        if (kind == 2 && lat == 1) begin
            $display("load at %h answered like a hit on a line that was not cached", addr);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        #1;
        if (addr_ok !== 1'b1) begin
            $display("Fail addr_ok after reset: got %h expected %h", addr_ok, 1'b1);
            errors++;
        end
        if (data_ok !== 1'b0) begin
            $display("Fail data_ok after reset: got %h expected %h", data_ok, 1'b0);
            errors++;
        end
        if (rd_req !== 1'b0 || wr_req !== 1'b0) begin
            $display("a memory request is active right after reset");
            errors++;
        end
    endtask

    task automatic test_miss_then_hit();
        for (int i = 0; i < 8; i++) begin
            load_word(addr_of(20'h1, 8'(8'h10 + i), 2'(i)), 2);
        end
        for (int i = 0; i < 8; i++) begin
            load_word(addr_of(20'h1, 8'(8'h10 + i), 2'(i)), 1);
        end
    endtask

    // the load right after a store hit stalls on the store buffer
    task automatic test_store_hit();
        store_word(addr_of(20'h1, 8'h10, 2'd0), 4'b0110, 32'h1234_5678);
        load_word(addr_of(20'h1, 8'h10, 2'd0), 1);
        store_word(addr_of(20'h1, 8'h11, 2'd1), 4'b1001, 32'h8765_4321);
        store_word(addr_of(20'h1, 8'h11, 2'd1), 4'b0010, 32'h0000_aa00);
        load_word(addr_of(20'h1, 8'h11, 2'd1), 1);
    endtask

    task automatic test_store_miss();
        store_word(addr_of(20'h2, 8'h40, 2'd2), 4'b1100, 32'habcd_ef01);
        load_word(addr_of(20'h2, 8'h40, 2'd2), 1);
        load_word(addr_of(20'h2, 8'h40, 2'd3), 1);
    endtask

    // five tags into a two-way set force dirty evictions
    task automatic test_eviction(input logic [7:0] idx, input logic [15:0] salt);
        for (int t = 3; t < 8; t++) begin
            store_word(addr_of(20'(t), idx, 2'(t)), 4'hf, {8'(t), idx, salt});
        end
        for (int t = 3; t < 8; t++) begin
            load_word(addr_of(20'(t), idx, 2'(t)), 0);
            load_word(addr_of(20'(t), idx, 2'(t + 1)), 0);
        end
    endtask

    task automatic check_memory();
        int lines;
        lines = 0;
        for (int l = 0; l < 2048; l++) begin
            if (evicted[l]) begin
                lines++;
                for (int b = 0; b < 4; b++) begin
                    if (u_mem.mem[4*l + b] !== shadow[4*l + b]) begin
                        $display("Fail mem[%h]: got %h expected %h", 4*(4*l + b),
                                 u_mem.mem[4*l + b], shadow[4*l + b]);
                        errors++;
                    end
                end
            end
        end
        if (lines == 0) begin
            $display("no dirty line was ever written back to memory");
            errors++;
        end
    endtask

    initial begin
        resetn   = 1'b0;
        valid    = 1'b0;
        op       = 1'b0;
        index    = '0;
        tag      = '0;
        offset   = '0;
        wstrb    = '0;
        wdata    = '0;
        stall_en = 1'b0;
        for (int w = 0; w < 8192; w++) begin
            shadow[w]    = fill_word(w);
            u_mem.mem[w] = fill_word(w);
        end
        repeat (2) @(negedge clk);
        resetn = 1'b1;

        check_reset_state();
        test_miss_then_hit();
        test_store_hit();
        test_store_miss();
        test_eviction(8'h80, 16'h1357);
        @(negedge clk);
        stall_en = 1'b1;
        test_eviction(8'h91, 16'h5a5a);
        @(negedge clk);
        stall_en = 1'b0;
        check_memory();

        errors += u_dcache_top.u_dcache_assert.fail_cnt;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dcache.f
design/dcache_pkg.sv
design/dcache_data_bank.sv
design/dcache_tag_array.sv
design/dcache_store_buffer.sv
design/dcache_main_fsm.sv
design/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_assert.sv
bench/dcache_tb.sv
